// File: Bender.yml
package:
  name: softmax

export_include_dirs:
  - include

sources:
  - files:
      - design/softmax_fmt_pkg.sv
      - design/softmax_frame_pkg.sv
      - design/softmax_if.sv
      - design/exp_stage.sv
      - design/exp_vector_buffer.sv
      - design/norm_divider.sv
      - design/softmax_top.sv
  - target: test
    files:
      - test/softmax_checker.sv
      - test/softmax_tb.sv

// File: design/exp_stage.sv
`timescale 1ns/1ps
`include "softmax_defines.svh"

module exp_stage (
  input logic clk,
  input logic rst,
  input logic in_valid,
  output logic in_ready,
  input softmax_fmt_pkg::in_val_t in_data,
  exp_stream_if.source exp_out
);
  import softmax_fmt_pkg::*;
  import softmax_frame_pkg::*;

  localparam int LUT_SIZE = 1 << `IN_W;

  exp_val_t exp_lut [LUT_SIZE];
  logic [`IN_W-1:0] lut_addr;
  logic armed; // low in reset so in_ready stays low there
  logic take;
  logic vld_q;
  logic last_q;
  exp_val_t exp_q;
  elem_idx_t idx;

  // table entry from real math at elaboration only
  function automatic exp_val_t exp_entry(input int code);
    logic signed [`IN_W-1:0] x_fix;
    real x;
    x_fix = code[`IN_W-1:0];
    x = real'(x_fix) / real'(1 << `IN_FRAC);
    return exp_val_t'($rtoi($floor($exp(x) * real'(1 << EXP_FRAC) + 0.5)));
  endfunction

  for (genvar i = 0; i < LUT_SIZE; i++) begin : g_lut
    localparam exp_val_t ENTRY = exp_entry(i);
    assign exp_lut[i] = ENTRY;
  end

  assign lut_addr = in_data; // two's complement code as table index
  assign in_ready = armed && (!vld_q || exp_out.ready);
  assign take = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b0;
      vld_q <= 1'b0;
      idx <= '0;
    end else begin
      armed <= 1'b1;
      if (take) begin
        vld_q <= 1'b1;
        idx <= idx + 1'b1; // wraps after VEC_LEN elements
      end else if (exp_out.ready) begin
        vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      exp_q <= exp_lut[lut_addr];
      last_q <= (idx == elem_idx_t'(`VEC_LEN - 1));
    end
  end

  assign exp_out.valid = vld_q;
  assign exp_out.exp = exp_q;
  assign exp_out.last = last_q;

endmodule

// File: design/exp_vector_buffer.sv
`timescale 1ns/1ps
`include "softmax_defines.svh"

module exp_vector_buffer (
  input logic clk,
  input logic rst,
  exp_stream_if.sink exp_in,
  norm_stream_if.source norm_out
);
  import softmax_fmt_pkg::*;
  import softmax_frame_pkg::*;

  localparam int DEPTH = 2 * `VEC_LEN; // one vector draining, one filling
  localparam int PTR_W = $clog2(DEPTH);

  exp_val_t exp_mem [DEPTH];
  logic last_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;

  sum_val_t run_sum; // vector being filled
  sum_val_t new_sum;
  sum_val_t held_sum; // vector being drained
  sum_val_t pend_sum; // next complete vector
  vec_cnt_t sum_cnt;

  logic wr;
  logic rd;
  logic complete;
  logic release_sum;

  // a third sum has nowhere to go, so hold back that last element
  assign exp_in.ready = (count != (PTR_W+1)'(DEPTH)) &&
                        !(exp_in.last && sum_cnt == 2'd2);

  assign wr = exp_in.valid && exp_in.ready;
  assign complete = wr && exp_in.last;
  assign new_sum = run_sum + sum_val_t'(exp_in.exp);

  // only the held vector may drain
  assign norm_out.valid = (count != '0) && (sum_cnt != '0);
  assign norm_out.exp = exp_mem[rd_ptr];
  assign norm_out.last = last_mem[rd_ptr];
  assign norm_out.sum = held_sum;

  assign rd = norm_out.valid && norm_out.ready;
  assign release_sum = rd && norm_out.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      run_sum <= '0;
      sum_cnt <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
        run_sum <= exp_in.last ? '0 : new_sum;
      end
      if (rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(wr) - (PTR_W+1)'(rd);
      sum_cnt <= sum_cnt + vec_cnt_t'(complete) - vec_cnt_t'(release_sum);
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      exp_mem[wr_ptr] <= exp_in.exp;
      last_mem[wr_ptr] <= exp_in.last;
    end
    if (complete) begin
      // straight to held if that slot is free or frees now
      if (sum_cnt == 2'd0 || (sum_cnt == 2'd1 && release_sum)) begin
        held_sum <= new_sum;
      end else begin
        pend_sum <= new_sum;
      end
    end
    if (release_sum && sum_cnt == 2'd2) begin
      held_sum <= pend_sum; // pending vector moves up
    end
  end

endmodule

// File: design/norm_divider.sv
`timescale 1ns/1ps
`include "softmax_defines.svh"

module norm_divider (
  input logic clk,
  input logic rst,
  norm_stream_if.sink norm_in,
  output logic out_valid,
  input logic out_ready,
  output softmax_fmt_pkg::out_val_t out_data,
  output logic out_last
);
  import softmax_fmt_pkg::*;

  localparam int SHIFT = OUT_FRAC + 1; // one extra bit for rounding
  localparam int Q_W = `EXP_W + SHIFT;
  localparam int LAST = `DIV_STAGES - 1;

  logic adv; // shared stage enable
  logic [Q_W-1:0] dividend;
  logic [Q_W-1:0] quot;
  logic [Q_W-1:0] q_pipe [LAST];
  logic [Q_W-1:0] q_round;
  logic [LAST:0] v_pipe;
  logic [LAST:0] l_pipe;
  out_val_t sat;
  out_val_t out_q;

  assign adv = !(v_pipe[LAST] && !out_ready);
  assign norm_in.ready = adv;

  assign dividend = {norm_in.exp, {SHIFT{1'b0}}};

  // all-zero vector gives 0 instead of a divide by zero
  always_comb begin
    if (norm_in.sum == '0) quot = '0;
    else quot = dividend / Q_W'(norm_in.sum);
  end

  assign q_round = (q_pipe[LAST-1] >> 1) + Q_W'(q_pipe[LAST-1][0]); // half up

  always_comb begin
    if (q_round > Q_W'({`OUT_W{1'b1}})) sat = '1;
    else sat = q_round[`OUT_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v_pipe <= '0;
      l_pipe <= '0;
    end else if (adv) begin
      v_pipe <= {v_pipe[LAST-1:0], norm_in.valid};
      l_pipe <= {l_pipe[LAST-1:0], norm_in.valid && norm_in.last};
    end
  end

  // quotient retimed, rounding lands in the final stage
  always_ff @(posedge clk) begin
    if (adv) begin
      q_pipe[0] <= quot;
      for (int i = 1; i < LAST; i++) begin
        q_pipe[i] <= q_pipe[i-1];
      end
      out_q <= sat;
    end
  end

  assign out_valid = v_pipe[LAST];
  assign out_last = l_pipe[LAST];
  assign out_data = out_q;

endmodule

// File: design/softmax_fmt_pkg.sv
`include "softmax_defines.svh"

package softmax_fmt_pkg;

  // fraction bits of the exp table entries and of the result
  localparam int EXP_FRAC = 4;
  localparam int OUT_FRAC = 4;

  // exact sum of VEC_LEN exp values
  localparam int SUM_W = `EXP_W + $clog2(`VEC_LEN);

  typedef logic signed [`IN_W-1:0] in_val_t; // raw input element

  typedef logic [`EXP_W-1:0] exp_val_t; // round(exp(x) * 16)

  typedef logic [SUM_W-1:0] sum_val_t;

  typedef logic [`OUT_W-1:0] out_val_t; // 1.0 is 16

endpackage

// File: design/softmax_frame_pkg.sv
`include "softmax_defines.svh"

package softmax_frame_pkg;

  // position of an element inside its vector
  typedef logic [$clog2(`VEC_LEN)-1:0] elem_idx_t;

  typedef logic [1:0] vec_cnt_t; // sums held plus pending, 0 to 2

endpackage

// File: design/softmax_if.sv
`timescale 1ns/1ps

// exp values from the exponent stage into the vector buffer
interface exp_stream_if;
  import softmax_fmt_pkg::*;

  logic valid;
  logic ready;
  exp_val_t exp;
  logic last; // final element of a vector

  modport source (output valid, exp, last, input ready);
  modport sink (input valid, exp, last, output ready);

endinterface

// exp value paired with the sum of its vector, into the divider
interface norm_stream_if;
  import softmax_fmt_pkg::*;

  logic valid;
  logic ready;
  exp_val_t exp;
  sum_val_t sum; // constant across one vector
  logic last;

  modport source (output valid, exp, sum, last, input ready);
  modport sink (input valid, exp, sum, last, output ready);

endinterface

// File: design/softmax_top.sv
`timescale 1ns/1ps

module softmax_top (
  input logic clk,
  input logic rst,
  input logic in_valid,
  output logic in_ready,
  input softmax_fmt_pkg::in_val_t in_data,
  output logic out_valid,
  input logic out_ready,
  output softmax_fmt_pkg::out_val_t out_data,
  output logic out_last
);

  exp_stream_if exp_bus ();
  norm_stream_if norm_bus ();

  exp_stage u_exp_stage (
    .clk (clk),
    .rst (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data (in_data),
    .exp_out (exp_bus.source)
  );

  exp_vector_buffer u_exp_vector_buffer (
    .clk (clk),
    .rst (rst),
    .exp_in (exp_bus.sink),
    .norm_out (norm_bus.source)
  );

  norm_divider u_norm_divider (
    .clk (clk),
    .rst (rst),
    .norm_in (norm_bus.sink),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data (out_data),
    .out_last (out_last)
  );

endmodule

// File: include/softmax_defines.svh
`ifndef SOFTMAX_DEFINES_SVH
`define SOFTMAX_DEFINES_SVH

// elements per vector, kept a power of two
`define VEC_LEN 8

// input element format, signed with fraction bits
`define IN_W 8
`define IN_FRAC 4

`define EXP_W 16 // exp table entry width
`define OUT_W 8 // softmax result width

`define DIV_STAGES 4 // divide and round pipeline depth

`endif

// File: softmax.f
+incdir+include
design/softmax_fmt_pkg.sv
design/softmax_frame_pkg.sv
design/softmax_if.sv
design/exp_stage.sv
design/exp_vector_buffer.sv
design/norm_divider.sv
design/softmax_top.sv
test/softmax_checker.sv
test/softmax_tb.sv

// File: test/softmax_checker.sv
`timescale 1ns/1ps
`include "softmax_defines.svh"

module softmax_checker (
  input logic clk,
  input logic rst,
  input logic in_ready,
  input logic out_valid,
  input logic out_ready,
  input softmax_fmt_pkg::out_val_t out_data,
  input logic out_last
);
  import softmax_frame_pkg::*;

  int unsigned fail_cnt = 0; // read by the testbench at the end
  elem_idx_t out_idx; // position of the next output in its vector

  always_ff @(posedge clk) begin
    if (rst) out_idx <= '0;
    else if (out_valid && out_ready) out_idx <= out_idx + 1'b1;
  end

  // a stalled result must not move
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
  else begin
    $error("output dropped or changed while stalled");
    fail_cnt++;
  end

  // first reset edge only clears the registers
  a_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> (!in_ready && !out_valid))
  else begin
    $error("handshake active during reset");
    fail_cnt++;
  end

  a_last: assert property (@(posedge clk) disable iff (rst)
    (out_valid && out_ready) |-> (out_last == (out_idx == elem_idx_t'(`VEC_LEN - 1))))
  else begin
    $error("out_last not on the final element of a vector");
    fail_cnt++;
  end

endmodule

// File: test/softmax_tb.sv
`timescale 1ns/1ps
`include "softmax_defines.svh"

module softmax_tb;
  import softmax_fmt_pkg::*;

  localparam int NUM_VEC = 4;
  localparam int NUM_ELEMS = NUM_VEC * `VEC_LEN;
  localparam int MAX_CYCLES = NUM_ELEMS * 20 + 200;
  localparam int GAP_ELEMS = 2 * `VEC_LEN; // later vectors come back to back

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  in_val_t in_data;
  logic out_valid;
  logic out_ready;
  out_val_t out_data;
  logic out_last;

  logic [`IN_W+`OUT_W+3:0] vec_mem [NUM_ELEMS]; // input, expected, last nibble
  integer seed;
  int sent;
  int received;
  int cycles;
  int data_errs;
  int last_errs;
  int other_errs;

  softmax_top UUT (
    .clk (clk),
    .rst (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data (out_data),
    .out_last (out_last)
  );

  bind softmax_top softmax_checker u_checker (
    .clk (clk),
    .rst (rst),
    .in_ready (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data (out_data),
    .out_last (out_last)
  );

  function automatic in_val_t input_of(input int i);
    return in_val_t'(vec_mem[i][`IN_W+`OUT_W+3 -: `IN_W]);
  endfunction

  function automatic out_val_t expected_of(input int i);
    return out_val_t'(vec_mem[i][`OUT_W+3 -: `OUT_W]);
  endfunction

  function automatic logic last_of(input int i);
    return vec_mem[i][0];
  endfunction

  always #20 clk = ~clk;

  // sampled values are the ones the DUT saw at this edge
  task automatic step_input();
    if (in_valid && in_ready) sent++;
    if (sent == NUM_ELEMS) begin
      in_valid <= 1'b0;
    end else if (!in_valid || in_ready) begin
      if (sent < GAP_ELEMS && ($random(seed) & 3) == 0) begin
        in_valid <= 1'b0; // idle gap
      end else begin
        in_valid <= 1'b1;
        in_data <= input_of(sent);
      end
    end
  endtask

  task automatic step_output();
    if (out_valid && out_ready) begin
      if (received < NUM_ELEMS) begin
        assert (out_data == expected_of(received)) else begin
          $display("ERR %0t: element %0d out_data %0d, expected %0d",
                   $time, received, out_data, expected_of(received));
          data_errs++;
        end
        assert (out_last == last_of(received)) else begin
          $display("ERR %0t: element %0d out_last %0b, expected %0b",
                   $time, received, out_last, last_of(received));
          last_errs++;
        end
      end
      received++;
    end
    out_ready <= (($random(seed) & 7) > 2); // low about a third of the time
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    seed = 32'h522a4c0d;
    sent = 0;
    received = 0;
    cycles = 0;
    data_errs = 0;
    last_errs = 0;
    other_errs = 0;
    $readmemh("test/softmax_testdata.txt", vec_mem);
    if ($isunknown(vec_mem[NUM_ELEMS-1])) begin
      $display("testdata file missing or too short");
      other_errs++;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    while (received < NUM_ELEMS && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
      step_input();
      step_output();
    end
    if (received < NUM_ELEMS) begin
      $display("timeout after %0d cycles with %0d of %0d outputs received",
               cycles, received, NUM_ELEMS);
      other_errs++;
    end else begin
      // anything arriving now is a duplicate
      repeat (2 * `DIV_STAGES + `VEC_LEN) begin
        @(posedge clk);
        step_output();
      end
      if (received != sent) begin
        $display("output count %0d differs from input count %0d", received, sent);
        other_errs++;
      end
    end
    $display("errors: data %0d, last %0d, other %0d, checker %0d",
             data_errs, last_errs, other_errs, UUT.u_checker.fail_cnt);
    if (data_errs + last_errs + other_errs + UUT.u_checker.fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: test/softmax_testdata.txt
// one element per line as IIEEL: input code, expected output, last flag
// four vectors of eight, expected = round half up of (exp << 5) / sum
00020
00020
00020
00020
00020
00020
00020
00021
00000
10010
20030
F0000
E0000
08010
F8000
30091
80000
80000
7F100
80000
80000
80000
80000
80001
18010
04000
FC000
00000
D0000
400D0
10010
F8001
